/* verilog/ex_pkg.sv */
package ex_pkg;

	// fixed by the ISA.
	localparam int unsigned XLEN = 32;
	localparam int unsigned REG_ADDR_W = 5;
	localparam int unsigned SHAMT_W = 5;

	// funct3 position inside the instruction word.
	localparam int unsigned F3_LSB = 12;
	localparam int unsigned F3_W = 3;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [F3_W-1:0]       funct3_t;
	typedef logic [3:0]            alu_op_t;
	typedef logic [1:0]            fwd_sel_t;
	typedef logic [1:0]            wb_sel_t;

	// unlisted alu codes give zero.
	localparam alu_op_t ALU_ADD    = 4'd0;
	localparam alu_op_t ALU_SUB    = 4'd1;
	localparam alu_op_t ALU_SLL    = 4'd2;
	localparam alu_op_t ALU_SLT    = 4'd3;
	localparam alu_op_t ALU_SLTU   = 4'd4;
	localparam alu_op_t ALU_XOR    = 4'd5;
	localparam alu_op_t ALU_SRL    = 4'd6;
	localparam alu_op_t ALU_SRA    = 4'd7;
	localparam alu_op_t ALU_OR     = 4'd8;
	localparam alu_op_t ALU_AND    = 4'd9;
	localparam alu_op_t ALU_PASS_B = 4'd10;

	// code 3 falls back to the register value.
	localparam fwd_sel_t FWD_REG = 2'd0;
	localparam fwd_sel_t FWD_MEM = 2'd1;
	localparam fwd_sel_t FWD_WB  = 2'd2;

	// branch conditions.
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	// csr writes that take operand A unchanged.
	localparam funct3_t F3_CSRRW  = 3'b001;
	localparam funct3_t F3_CSRRWI = 3'b101;

	typedef struct packed {
		alu_op_t   alu_op;
		logic      a_pc;
		logic      b_imm;
		logic      csr_alu;
		logic      is_branch;
		logic      is_jump;
		logic      is_mret;
		logic      mem_we;
		logic      mem_valid;
		wb_sel_t   wb_sel;
		logic      reg_we;
		reg_addr_t rd;
		logic      csr_we;
	} ex_ctrl_t;

	typedef struct packed {
		word_t rs1;
		word_t rs2;
		word_t imm;
		word_t pc;
		word_t pc4;
		word_t inst;
		word_t csr_rdata;
		word_t csr_waddr;
	} ex_data_t;

	typedef struct packed {
		logic eq;
		logic lt;
		logic ltu;
	} br_flags_t;

	typedef struct packed {
		logic  taken;
		word_t target;
	} redirect_t;

	typedef struct packed {
		word_t     alu;
		word_t     store_data;
		word_t     pc4;
		word_t     inst;
		word_t     csr_rdata;
		word_t     csr_waddr;
		logic      mem_we;
		logic      mem_valid;
		wb_sel_t   wb_sel;
		logic      reg_we;
		reg_addr_t rd;
		logic      csr_we;
	} ex_mem_t;

endpackage

/* verilog/ex_operand_sel.sv */
module ex_operand_sel (
	input  ex_pkg::ex_data_t data_i,
	input  ex_pkg::ex_ctrl_t ctrl_i,
	input  ex_pkg::word_t    mem_fwd_i,
	input  ex_pkg::word_t    wb_fwd_i,
	input  ex_pkg::fwd_sel_t fwd_a_i,
	input  ex_pkg::fwd_sel_t fwd_b_i,
	output ex_pkg::word_t    fwd_rs1_o,
	output ex_pkg::word_t    fwd_rs2_o,
	output ex_pkg::word_t    op_a_o,
	output ex_pkg::word_t    op_b_o
);
	import ex_pkg::*;

	funct3_t funct3;
	logic    csr_zero;

	// pick the freshest copy of a register operand.
	function automatic word_t fwd_pick(
		input fwd_sel_t sel,
		input word_t    reg_val,
		input word_t    mem_val,
		input word_t    wb_val
	);
		word_t res;
		case (sel)
			FWD_REG: res = reg_val;
			FWD_MEM: res = mem_val;
			FWD_WB:  res = wb_val;
			default: res = reg_val;
		endcase
		return res;
	endfunction

	assign fwd_rs1_o = fwd_pick(fwd_a_i, data_i.rs1, mem_fwd_i, wb_fwd_i);
	assign fwd_rs2_o = fwd_pick(fwd_b_i, data_i.rs2, mem_fwd_i, wb_fwd_i);

	// auipc and jal add to pc.
	assign op_a_o = ctrl_i.a_pc ? data_i.pc : fwd_rs1_o;

	assign funct3 = data_i.inst[F3_LSB +: F3_W];

	// csrrw/csrrwi write operand A as is.
	assign csr_zero = (funct3 == F3_CSRRW) || (funct3 == F3_CSRRWI);

	always_comb begin
		if (ctrl_i.csr_alu) begin
			// set/clear ops combine with the old csr value.
			if (csr_zero) begin
				op_b_o = '0;
			end else begin
				op_b_o = data_i.csr_rdata;
			end
		end else if (ctrl_i.b_imm) begin
			op_b_o = data_i.imm;
		end else begin
			op_b_o = fwd_rs2_o;
		end
	end

endmodule

/* verilog/ex_alu.sv */
module ex_alu (
	input  ex_pkg::word_t   op_a_i,
	input  ex_pkg::word_t   op_b_i,
	input  ex_pkg::alu_op_t alu_op_i,
	output ex_pkg::word_t   result_o
);
	import ex_pkg::*;

	logic [SHAMT_W-1:0] shamt;

	// only the low bits count for rv32 shifts.
	assign shamt = op_b_i[SHAMT_W-1:0];

	always_comb begin
		case (alu_op_i)
			ALU_ADD: begin
				result_o = op_a_i + op_b_i;
			end
			ALU_SUB: begin
				result_o = op_a_i - op_b_i;
			end
			ALU_SLL: begin
				result_o = op_a_i << shamt;
			end
			ALU_SLT: begin
				result_o = word_t'($signed(op_a_i) < $signed(op_b_i));
			end
			ALU_SLTU: begin
				result_o = word_t'(op_a_i < op_b_i);
			end
			ALU_XOR: begin
				result_o = op_a_i ^ op_b_i;
			end
			ALU_SRL: begin
				result_o = op_a_i >> shamt;
			end
			ALU_SRA: begin
				// sign fill from bit 31.
				result_o = word_t'($signed(op_a_i) >>> shamt);
			end
			ALU_OR: begin
				result_o = op_a_i | op_b_i;
			end
			ALU_AND: begin
				result_o = op_a_i & op_b_i;
			end
			ALU_PASS_B: begin
				// lui.
				result_o = op_b_i;
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

/* verilog/ex_branch_cmp.sv */
module ex_branch_cmp (
	input  ex_pkg::word_t     rs1_i,
	input  ex_pkg::word_t     rs2_i,
	output ex_pkg::br_flags_t flags_o
);
	import ex_pkg::*;

	logic [XLEN:0] diff;
	logic          sign_differs;

	// one subtractor serves both orderings.
	assign diff = {1'b0, rs1_i} - {1'b0, rs2_i};

	assign sign_differs = rs1_i[XLEN-1] ^ rs2_i[XLEN-1];

	assign flags_o.eq = (rs1_i == rs2_i);

	// borrow out means rs1 below rs2.
	assign flags_o.ltu = diff[XLEN];

	// with mixed signs the negative one is smaller.
	assign flags_o.lt = sign_differs ? rs1_i[XLEN-1] : diff[XLEN];

endmodule

/* verilog/ex_resolve_reg.sv */
module ex_resolve_reg (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              enable_i,
	input  logic              flush_i,
	input  ex_pkg::ex_ctrl_t  ctrl_i,
	input  ex_pkg::ex_data_t  data_i,
	input  ex_pkg::word_t     alu_result_i,
	input  ex_pkg::br_flags_t flags_i,
	input  ex_pkg::word_t     store_data_i,
	input  ex_pkg::word_t     mret_pc_i,
	output ex_pkg::redirect_t redirect_o,
	output ex_pkg::ex_mem_t   ex_mem_o
);
	import ex_pkg::*;

	funct3_t funct3;
	logic    br_taken;
	ex_mem_t ex_mem_d;
	ex_mem_t ex_mem_q;

	assign funct3 = data_i.inst[F3_LSB +: F3_W];

	// funct3 also tells signed from unsigned.
	always_comb begin
		case (funct3)
			F3_BEQ:  br_taken = flags_i.eq;
			F3_BNE:  br_taken = ~flags_i.eq;
			F3_BLT:  br_taken = flags_i.lt;
			F3_BGE:  br_taken = ~flags_i.lt;
			F3_BLTU: br_taken = flags_i.ltu;
			F3_BGEU: br_taken = ~flags_i.ltu;
			default: br_taken = 1'b0;
		endcase
	end

	// mret wins over everything else.
	always_comb begin
		redirect_o.taken  = 1'b0;
		redirect_o.target = alu_result_i;
		if (ctrl_i.is_mret) begin
			redirect_o.taken  = 1'b1;
			redirect_o.target = mret_pc_i;
		end else if (ctrl_i.is_jump) begin
			redirect_o.taken = 1'b1;
		end else if (ctrl_i.is_branch) begin
			redirect_o.taken = br_taken;
		end
	end

	always_comb begin
		ex_mem_d.alu        = alu_result_i;
		ex_mem_d.store_data = store_data_i;
		ex_mem_d.pc4        = data_i.pc4;
		ex_mem_d.inst       = data_i.inst;
		ex_mem_d.csr_rdata  = data_i.csr_rdata;
		ex_mem_d.csr_waddr  = data_i.csr_waddr;
		ex_mem_d.mem_we     = ctrl_i.mem_we;
		ex_mem_d.mem_valid  = ctrl_i.mem_valid;
		ex_mem_d.wb_sel     = ctrl_i.wb_sel;
		ex_mem_d.reg_we     = ctrl_i.reg_we;
		ex_mem_d.rd         = ctrl_i.rd;
		ex_mem_d.csr_we     = ctrl_i.csr_we;
	end

	// stall holds, flush inserts a bubble.
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			ex_mem_q <= '0;
		end else if (enable_i) begin
			if (flush_i) begin
				ex_mem_q <= '0;
			end else begin
				ex_mem_q <= ex_mem_d;
			end
		end
	end

	assign ex_mem_o = ex_mem_q;

endmodule

/* verilog/ex_stage.sv */
module ex_stage (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              enable_i,
	input  logic              flush_i,
	input  ex_pkg::ex_ctrl_t  ex_ctrl_i,
	input  ex_pkg::ex_data_t  ex_data_i,
	input  ex_pkg::word_t     wb_data_i,
	input  ex_pkg::fwd_sel_t  fwd_a_i,
	input  ex_pkg::fwd_sel_t  fwd_b_i,
	input  ex_pkg::word_t     mret_pc_i,
	output ex_pkg::ex_mem_t   ex_mem_o,
	output ex_pkg::redirect_t redirect_o,
	output ex_pkg::br_flags_t br_flags_o
);
	import ex_pkg::*;

	word_t op_a;
	word_t op_b;
	word_t fwd_rs1;
	word_t fwd_rs2;
	word_t alu_result;

	// mem forward comes from the bundle already in the register.
	ex_operand_sel u_operand_sel (
		.data_i    (ex_data_i),
		.ctrl_i    (ex_ctrl_i),
		.mem_fwd_i (ex_mem_o.alu),
		.wb_fwd_i  (wb_data_i),
		.fwd_a_i   (fwd_a_i),
		.fwd_b_i   (fwd_b_i),
		.fwd_rs1_o (fwd_rs1),
		.fwd_rs2_o (fwd_rs2),
		.op_a_o    (op_a),
		.op_b_o    (op_b)
	);

	ex_alu u_alu (
		.op_a_i   (op_a),
		.op_b_i   (op_b),
		.alu_op_i (ex_ctrl_i.alu_op),
		.result_o (alu_result)
	);

	// compares the register values, not the alu operands.
	ex_branch_cmp u_branch_cmp (
		.rs1_i   (fwd_rs1),
		.rs2_i   (fwd_rs2),
		.flags_o (br_flags_o)
	);

	ex_resolve_reg u_resolve_reg (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.enable_i     (enable_i),
		.flush_i      (flush_i),
		.ctrl_i       (ex_ctrl_i),
		.data_i       (ex_data_i),
		.alu_result_i (alu_result),
		.flags_i      (br_flags_o),
		.store_data_i (fwd_rs2),
		.mret_pc_i    (mret_pc_i),
		.redirect_o   (redirect_o),
		.ex_mem_o     (ex_mem_o)
	);

endmodule

/* test/ex_model.svh */
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// galois form with the mask folded in when bit 0 shifts out.
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	if (s[0]) begin
		return (s >> 1) ^ 32'h8020_0003;
	end
	return s >> 1;
endfunction

function automatic word_t model_alu(input alu_op_t op, input word_t a, input word_t b);
	logic [63:0] ext;
	logic [4:0]  sh;
	word_t       r;
	sh  = b[4:0];
	ext = {{32{a[31]}}, a} >> sh;
	case (op)
		ALU_ADD:    r = a + b;
		ALU_SUB:    r = a + ~b + 32'd1;
		ALU_SLL:    r = a << sh;
		ALU_SLT:    r = {31'd0, $signed(a) < $signed(b)};
		ALU_SLTU:   r = {31'd0, a < b};
		ALU_XOR:    r = a ^ b;
		ALU_SRL:    r = a >> sh;
		ALU_SRA:    r = ext[31:0];
		ALU_OR:     r = a | b;
		ALU_AND:    r = a & b;
		ALU_PASS_B: r = b;
		default:    r = '0;
	endcase
	return r;
endfunction

function automatic br_flags_t model_flags(input word_t a, input word_t b);
	br_flags_t f;
	f.eq  = (a == b);
	f.ltu = (a < b);
	f.lt  = ($signed(a) < $signed(b));
	return f;
endfunction

function automatic void model_operands(
	input  ex_data_t data,
	input  ex_ctrl_t ctrl,
	input  word_t    mem_fwd,
	input  word_t    wb,
	input  fwd_sel_t fa,
	input  fwd_sel_t fb,
	output word_t    rs1,
	output word_t    rs2,
	output word_t    a,
	output word_t    b
);
	logic [2:0] f3;
	f3  = data.inst[14:12];
	rs1 = (fa == 2'd1) ? mem_fwd : (fa == 2'd2) ? wb : data.rs1;
	rs2 = (fb == 2'd1) ? mem_fwd : (fb == 2'd2) ? wb : data.rs2;
	a   = ctrl.a_pc ? data.pc : rs1;
	if (ctrl.csr_alu) begin
		b = (f3 == 3'b001 || f3 == 3'b101) ? 32'd0 : data.csr_rdata;
	end else begin
		b = ctrl.b_imm ? data.imm : rs2;
	end
endfunction

function automatic redirect_t model_redirect(
	input ex_ctrl_t   ctrl,
	input logic [2:0] f3,
	input br_flags_t  fl,
	input word_t      alu,
	input word_t      mret_pc
);
	redirect_t r;
	r.taken  = ctrl.is_mret | ctrl.is_jump;
	r.target = ctrl.is_mret ? mret_pc : alu;
	if (!r.taken && ctrl.is_branch) begin
		case (f3)
			3'b000:  r.taken = fl.eq;
			3'b001:  r.taken = !fl.eq;
			3'b100:  r.taken = fl.lt;
			3'b101:  r.taken = !fl.lt;
			3'b110:  r.taken = fl.ltu;
			3'b111:  r.taken = !fl.ltu;
			default: r.taken = 1'b0;
		endcase
	end
	return r;
endfunction

function automatic ex_mem_t model_ex_mem(
	input ex_ctrl_t ctrl,
	input ex_data_t data,
	input word_t    alu,
	input word_t    store
);
	ex_mem_t m;
	m = {alu, store, data.pc4, data.inst, data.csr_rdata, data.csr_waddr,
		ctrl.mem_we, ctrl.mem_valid, ctrl.wb_sel, ctrl.reg_we, ctrl.rd, ctrl.csr_we};
	return m;
endfunction

`endif

/* test/tb_ex_stage.sv */
module tb_ex_stage;
	import ex_pkg::*;

	`include "ex_model.svh"

	localparam logic [31:0] SEED = 32'd67312;
	localparam int PHASE_LEN = 400;
	localparam int RST_TIMEOUT = 40;
	localparam int RUN_TIMEOUT = 5000;
	localparam int PH_ALU = 0;
	localparam int PH_CSR = 2;
	localparam int PH_BRANCH = 3;
	localparam int PH_STALL = 4;

	logic      clk = 1'b0;
	logic      rst_ni;
	logic      enable;
	logic      flush;
	ex_ctrl_t  ex_ctrl;
	ex_data_t  ex_data;
	word_t     wb_data;
	fwd_sel_t  fwd_a;
	fwd_sel_t  fwd_b;
	word_t     mret_pc;
	ex_mem_t   ex_mem;
	redirect_t redirect;
	br_flags_t br_flags;

	logic [31:0] lfsr_q;
	ex_mem_t     model_q;
	int word_errs = 0;
	int flag_errs = 0;
	int redir_errs = 0;
	int exmem_errs = 0;
	int other_errs = 0;

	always #5 clk = ~clk;

	ex_stage u_ex_stage (
		.clk_i      (clk),
		.rst_ni     (rst_ni),
		.enable_i   (enable),
		.flush_i    (flush),
		.ex_ctrl_i  (ex_ctrl),
		.ex_data_i  (ex_data),
		.wb_data_i  (wb_data),
		.fwd_a_i    (fwd_a),
		.fwd_b_i    (fwd_b),
		.mret_pc_i  (mret_pc),
		.ex_mem_o   (ex_mem),
		.redirect_o (redirect),
		.br_flags_o (br_flags)
	);

	function automatic logic take_bit();
		lfsr_q = lfsr_step(lfsr_q);
		return lfsr_q[0];
	endfunction

	function automatic word_t take_bits(input int n);
		word_t v;
		int    i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], take_bit()};
		end
		return v;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			word_errs++;
			$display("Fail %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_flags(input br_flags_t got, input br_flags_t exp);
		if (got !== exp) begin
			flag_errs++;
			$display("Fail br_flags_o got 0x%h expected 0x%h", got, exp);
		end
	endtask

	task automatic check_redirect(input redirect_t got, input redirect_t exp);
		if (got !== exp) begin
			redir_errs++;
			$display("Fail redirect_o got 0x%h expected 0x%h", got, exp);
		end
	endtask

	task automatic check_ex_mem(input ex_mem_t got, input ex_mem_t exp);
		if (got !== exp) begin
			exmem_errs++;
			$display("Fail ex_mem_o got 0x%h expected 0x%h", got, exp);
		end
	endtask

	task automatic drive_random(input int phase);
		logic [1:0] pick;
		ex_ctrl = '0;
		ex_ctrl.alu_op    = alu_op_t'(take_bits(4));
		ex_ctrl.a_pc      = take_bit();
		ex_ctrl.b_imm     = take_bit();
		ex_ctrl.mem_we    = take_bit();
		ex_ctrl.mem_valid = take_bit();
		ex_ctrl.wb_sel    = wb_sel_t'(take_bits(2));
		ex_ctrl.reg_we    = take_bit();
		ex_ctrl.rd        = reg_addr_t'(take_bits(5));
		ex_ctrl.csr_we    = take_bit();
		ex_data = {take_bits(32), take_bits(32), take_bits(32), take_bits(32),
			take_bits(32), take_bits(32), take_bits(32), take_bits(32)};
		wb_data = take_bits(32);
		mret_pc = take_bits(32);
		enable  = 1'b1;
		flush   = 1'b0;
		fwd_a   = (phase == PH_ALU) ? FWD_REG : fwd_sel_t'(take_bits(2));
		fwd_b   = (phase == PH_ALU) ? FWD_REG : fwd_sel_t'(take_bits(2));
		if (phase == PH_CSR) begin
			ex_ctrl.csr_alu = 1'b1;
		end else if (phase == PH_BRANCH) begin
			pick = 2'(take_bits(2));
			ex_ctrl.is_branch = 1'b1;
			ex_ctrl.is_jump   = (pick == 2'd0);
			ex_ctrl.is_mret   = (pick == 2'd1);
			// equal and sign-differing operand pairs.
			pick = 2'(take_bits(2));
			if (pick == 2'd0) begin
				ex_data.rs2 = ex_data.rs1;
			end else if (pick == 2'd1) begin
				ex_data.rs2 = ex_data.rs1 ^ 32'h8000_0000;
			end
		end else if (phase == PH_STALL) begin
			enable = (take_bits(2) != 0);
			flush  = (take_bits(2) == 0);
		end
	endtask

	task automatic run_cycle(input int phase);
		word_t     rs1f;
		word_t     rs2f;
		word_t     opa;
		word_t     opb;
		word_t     alu;
		br_flags_t fl;
		ex_mem_t   nxt;
		@(negedge clk);
		check_word("ex_mem_o.alu", ex_mem.alu, model_q.alu);
		check_word("ex_mem_o.store_data", ex_mem.store_data, model_q.store_data);
		check_ex_mem(ex_mem, model_q);
		drive_random(phase);
		#1;
		// mem forward is the alu field of the bundle already held.
		model_operands(ex_data, ex_ctrl, model_q.alu, wb_data, fwd_a, fwd_b,
			rs1f, rs2f, opa, opb);
		alu = model_alu(ex_ctrl.alu_op, opa, opb);
		fl  = model_flags(rs1f, rs2f);
		check_flags(br_flags, fl);
		check_redirect(redirect, model_redirect(ex_ctrl, ex_data.inst[14:12], fl, alu, mret_pc));
		if (!enable) begin
			nxt = model_q;
		end else if (flush) begin
			nxt = '0;
		end else begin
			nxt = model_ex_mem(ex_ctrl, ex_data, alu, rs2f);
		end
		@(posedge clk);
		model_q = nxt;
	endtask

	task automatic await_reset_release();
		int n;
		n = 0;
		while (rst_ni !== 1'b1 && n < RST_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (rst_ni !== 1'b1) begin
			other_errs++;
			$display("reset still asserted after %0d cycles", RST_TIMEOUT);
		end
	endtask

	initial begin
		rst_ni = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_ni = 1'b1;
	end

	initial begin : watchdog
		int n;
		for (n = 0; n < RUN_TIMEOUT; n++) begin
			@(posedge clk);
		end
		$display("run did not complete within %0d cycles", RUN_TIMEOUT);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin : main_flow
		int phase;
		int total;
		enable  = 1'b0;
		flush   = 1'b0;
		ex_ctrl = '0;
		ex_data = '0;
		wb_data = '0;
		fwd_a   = FWD_REG;
		fwd_b   = FWD_REG;
		mret_pc = '0;
		lfsr_q  = SEED;
		model_q = '0;
		await_reset_release();
		check_ex_mem(ex_mem, ex_mem_t'(0));
		for (phase = PH_ALU; phase <= PH_STALL; phase++) begin
			repeat (PHASE_LEN) run_cycle(phase);
		end
		@(negedge clk);
		check_ex_mem(ex_mem, model_q);
		total = word_errs + flag_errs + redir_errs + exmem_errs + other_errs;
		$display("errors: word %0d, flags %0d, redirect %0d, ex_mem %0d, other %0d",
			word_errs, flag_errs, redir_errs, exmem_errs, other_errs);
		if (total == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+test
verilog/ex_pkg.sv
verilog/ex_operand_sel.sv
verilog/ex_alu.sv
verilog/ex_branch_cmp.sv
verilog/ex_resolve_reg.sv
verilog/ex_stage.sv
test/tb_ex_stage.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - files:
      - verilog/ex_pkg.sv
  - files:
      - verilog/ex_operand_sel.sv
      - verilog/ex_alu.sv
      - verilog/ex_branch_cmp.sv
      - verilog/ex_resolve_reg.sv
      - verilog/ex_stage.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_ex_stage.sv
